/* Makefile */
VERILATOR ?= verilator
TOP       ?= nobl_sram_tb
FILELIST  ?= nobl_sram_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "test passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* nobl_sram_top.f */
+incdir+source
source/nobl_pkg.sv
source/nobl_cmd_decode.sv
source/nobl_burst_addr.sv
source/nobl_mem_array.sv
source/nobl_read_out.sv
source/nobl_sram_top.sv
tb/nobl_sram_assertions.sv
tb/nobl_sram_tb.sv

/* source/nobl_burst_addr.sv */
`include "nobl_settings.svh"

module nobl_burst_addr (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    cen_n_i,
  input  logic                    mode_i,     // 1 = interleaved burst
  input  logic [`NOBL_ADDR_W-1:0] a_i,
  input  nobl_pkg::nobl_op_e      op_i,
  input  logic                    step_i,
  output logic [`NOBL_ADDR_W-1:0] rd_addr_o,  // address of the newest cycle
  output logic [`NOBL_ADDR_W-1:0] wr_addr_o   // address paired with wr_en
);

  import nobl_pkg::*;

  logic [`NOBL_ADDR_W-1:0] addr_q;     // access address, write stage 1
  logic [`NOBL_ADDR_W-1:0] wr_addr_q;  // write stage 2
  logic                    start_q;    // a[0] of the last load
  logic [1:0]              lo_next;    // next burst position

  // linear counts up, interleave from an odd start counts down
  always_comb
  begin
    if (!start_q || !mode_i)
      lo_next = addr_q[1:0] + 2'd1;
    else
      lo_next = addr_q[1:0] - 2'd1;
  end

  // ********************************************************************
  // address register
  // ********************************************************************

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      addr_q  <= '0;
      start_q <= 1'b0;
    end
    else if (!cen_n_i && step_i)
    begin
      case (op_i)
        OP_LOAD_RD, OP_LOAD_WR:
        begin
          addr_q  <= a_i;
          start_q <= a_i[0];
        end
        OP_BURST_RD, OP_BURST_WR:
          addr_q[1:0] <= lo_next;   // upper bits stay put
        default: ;
      endcase
    end
  end

  // second write stage lines up with wr_s2 in the decoder
  always_ff @(posedge clk)
  begin
    if (!cen_n_i)
      wr_addr_q <= addr_q;
  end

  assign rd_addr_o = addr_q;
  assign wr_addr_o = wr_addr_q;

endmodule

/* source/nobl_cmd_decode.sv */
module nobl_cmd_decode (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               cen_n_i,    // clock enable, low active
  input  logic               adv_i,      // 1 = burst continue, 0 = load
  input  logic               we_n_i,     // write type, sampled on loads
  input  logic [1:0]         bw_n_i,     // byte selects, fresh every cycle
  input  logic               ce1_n_i,
  input  logic               ce2_i,
  input  logic               ce3_n_i,
  output nobl_pkg::nobl_op_e op_o,       // class of the current cycle
  output logic               step_o,     // enabled and selected
  output logic               wr_en_o,    // write strobe, two stages late
  output logic [1:0]         wr_bw_n_o   // lanes for that strobe
);

  import nobl_pkg::*;

  logic       cyc_en;    // this edge is a real edge
  logic       cs_load;   // chip selects valid on a load cycle
  logic       sel_q;     // selection kept for bursts
  logic       wr_q;      // write type kept for bursts
  logic       sel_now;   // selection that applies to this cycle
  logic       wr_now;    // write type that applies to this cycle
  logic [1:0] bw_now;    // lanes of this cycle, all off for a read
  logic       wr_s1_q;   // write pipe, stage 1
  logic       wr_s2_q;   // write pipe, stage 2
  logic [1:0] bw_s1_q;
  logic [1:0] bw_s2_q;

  // ********************************************************************
  // cycle decode
  // ********************************************************************

  assign cyc_en  = ~cen_n_i;
  assign cs_load = ~ce1_n_i & ce2_i & ~ce3_n_i;  // all three must agree

  // bursts inherit what the last load decided
  assign sel_now = adv_i ? sel_q : cs_load;
  assign wr_now  = adv_i ? wr_q : ~we_n_i;
  assign bw_now  = wr_now ? bw_n_i : 2'b11;     // bw ignored on reads

  always_comb
  begin
    op_o = OP_IDLE;                              // stall or deselect
    if (cyc_en && sel_now)
    begin
      case ({adv_i, wr_now})
        2'b00:   op_o = OP_LOAD_RD;
        2'b01:   op_o = OP_LOAD_WR;
        2'b10:   op_o = OP_BURST_RD;
        default: op_o = OP_BURST_WR;
      endcase
    end
  end

  assign step_o = cyc_en & sel_now;  // address block moves only then

  // ********************************************************************
  // remembered load state and write pipe
  // ********************************************************************

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      sel_q   <= 1'b0;
      wr_q    <= 1'b0;
      wr_s1_q <= 1'b0;
      wr_s2_q <= 1'b0;
    end
    else if (cyc_en)
    begin
      // a load refreshes selection and write type, deselected or not
      if (!adv_i)
      begin
        sel_q <= cs_load;
        wr_q  <= ~we_n_i;
      end
      wr_s1_q <= sel_now & wr_now;   // bw = 11 still counts as a write
      wr_s2_q <= wr_s1_q;
    end
  end

  // lane selects follow the strobe, frozen on stalls
  always_ff @(posedge clk)
  begin
    if (cyc_en)
    begin
      bw_s1_q <= bw_now;
      bw_s2_q <= bw_s1_q;
    end
  end

  // array writes at the next enabled edge with d_i on the pins
  assign wr_en_o   = wr_s2_q;
  assign wr_bw_n_o = bw_s2_q;

endmodule

/* source/nobl_mem_array.sv */
`include "nobl_settings.svh"

module nobl_mem_array (
  input  logic                    clk,
  input  logic                    cen_n_i,
  input  logic [`NOBL_ADDR_W-1:0] rd_addr_i,
  input  logic [`NOBL_ADDR_W-1:0] wr_addr_i,
  input  logic                    wr_en_i,    // delayed write strobe
  input  logic [`NOBL_NBYTES-1:0] wr_bw_n_i,  // low = write that lane
  input  logic [`NOBL_WORD_W-1:0] d_i,        // pin data, taken this edge
  output nobl_pkg::nobl_word_u    q_o         // registered read word
);

  import nobl_pkg::*;

  localparam int DEPTH = 1 << `NOBL_ADDR_W;

  nobl_word_u mem [DEPTH];  // storage
  nobl_word_u din;          // pin data split into lanes

  assign din = nobl_word_u'(d_i);

  // ********************************************************************
  // read and write port
  // ********************************************************************

  // both ports act only on enabled edges
  always_ff @(posedge clk)
  begin
    if (!cen_n_i)
    begin
      // read before write, same-edge collision gives the old word
      q_o <= mem[rd_addr_i];

      if (wr_en_i)
      begin
        for (int b = 0; b < `NOBL_NBYTES; b++)
        begin
          if (!wr_bw_n_i[b])
            mem[wr_addr_i].lane[b] <= din.lane[b];  // one lane at a time
        end
      end
    end
  end

endmodule

/* source/nobl_pkg.sv */
package nobl_pkg;

`include "nobl_settings.svh"

  // ******************************************************************
  // cycle classification
  // ******************************************************************

  // one value per enabled cycle, idle covers deselect and stall
  typedef enum logic [2:0] {
    OP_IDLE     = 3'd0,  // deselected or clock disabled
    OP_LOAD_RD  = 3'd1,  // new address, read
    OP_LOAD_WR  = 3'd2,  // new address, write
    OP_BURST_RD = 3'd3,  // next burst address, read
    OP_BURST_WR = 3'd4   // next burst address, write
  } nobl_op_e;

  // ******************************************************************
  // data word
  // ******************************************************************

  // whole word for the read path, lanes for byte writes
  typedef union packed {
    logic [`NOBL_WORD_W-1:0]                   word;
    logic [`NOBL_NBYTES-1:0][`NOBL_BYTE_W-1:0] lane;  // lane[0] is bw_n[0]
  } nobl_word_u;

endpackage

/* source/nobl_read_out.sv */
`include "nobl_settings.svh"

module nobl_read_out (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    cen_n_i,
  input  nobl_pkg::nobl_op_e      op_i,
  input  nobl_pkg::nobl_word_u    q_i,      // word read from the array
  input  logic                    oe_n_i,   // async output enable
  output logic [`NOBL_WORD_W-1:0] d_o,
  output logic                    d_oe_o
);

  import nobl_pkg::*;

  logic rd_cmd;    // this cycle is a read
  logic rd_v1_q;   // read issued, address stage
  logic rd_v2_q;   // array stage
  logic out_v_q;   // output register holds read data

  assign rd_cmd = (op_i == OP_LOAD_RD) || (op_i == OP_BURST_RD);

  // ********************************************************************
  // valid pipe, idle and writes push a zero through
  // ********************************************************************

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      rd_v1_q <= 1'b0;
      rd_v2_q <= 1'b0;
      out_v_q <= 1'b0;
    end
    else if (!cen_n_i)
    begin
      rd_v1_q <= rd_cmd;
      rd_v2_q <= rd_v1_q;
      out_v_q <= rd_v2_q;
    end
  end

  // output data register, holds on stalls
  always_ff @(posedge clk)
  begin
    if (!cen_n_i)
      d_o <= q_i.word;
  end

  assign d_oe_o = out_v_q & ~oe_n_i;  // oe_n cuts the drive at once

endmodule

/* source/nobl_settings.svh */
`ifndef NOBL_SETTINGS_SVH
`define NOBL_SETTINGS_SVH

// ********************************************************************
// array geometry
// ********************************************************************

// word address width, the full device uses 20 (1M words)
`define NOBL_ADDR_W 10

// one data word as seen on the pins
`define NOBL_WORD_W 18

// byte lane width, 9 bits with parity position
`define NOBL_BYTE_W 9

// lanes per word, one bw_n select each
`define NOBL_NBYTES 2

`endif

/* source/nobl_sram_top.sv */
`include "nobl_settings.svh"

module nobl_sram_top (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic [`NOBL_ADDR_W-1:0] a_i,
  input  logic                    adv_i,
  input  logic                    we_n_i,
  input  logic [`NOBL_NBYTES-1:0] bw_n_i,
  input  logic                    ce1_n_i,
  input  logic                    ce2_i,
  input  logic                    ce3_n_i,
  input  logic                    cen_n_i,
  input  logic                    oe_n_i,
  input  logic                    mode_i,
  input  logic [`NOBL_WORD_W-1:0] d_i,
  output logic [`NOBL_WORD_W-1:0] d_o,
  output logic                    d_oe_o
);

  import nobl_pkg::*;

  nobl_op_e                op;       // cycle class
  logic                    step;     // address may move
  logic                    wr_en;    // delayed write strobe
  logic [`NOBL_NBYTES-1:0] wr_bw_n;
  logic [`NOBL_ADDR_W-1:0] rd_addr;
  logic [`NOBL_ADDR_W-1:0] wr_addr;
  nobl_word_u              q;        // array read word

  // ********************************************************************
  // pipeline blocks
  // ********************************************************************

  nobl_cmd_decode u_cmd_decode (
    .clk       (clk),
    .rst_i     (rst_i),
    .cen_n_i   (cen_n_i),
    .adv_i     (adv_i),
    .we_n_i    (we_n_i),
    .bw_n_i    (bw_n_i),
    .ce1_n_i   (ce1_n_i),
    .ce2_i     (ce2_i),
    .ce3_n_i   (ce3_n_i),
    .op_o      (op),
    .step_o    (step),
    .wr_en_o   (wr_en),
    .wr_bw_n_o (wr_bw_n)
  );

  nobl_burst_addr u_burst_addr (
    .clk       (clk),
    .rst_i     (rst_i),
    .cen_n_i   (cen_n_i),
    .mode_i    (mode_i),
    .a_i       (a_i),
    .op_i      (op),
    .step_i    (step),
    .rd_addr_o (rd_addr),
    .wr_addr_o (wr_addr)
  );

  nobl_mem_array u_mem_array (
    .clk       (clk),
    .cen_n_i   (cen_n_i),
    .rd_addr_i (rd_addr),
    .wr_addr_i (wr_addr),
    .wr_en_i   (wr_en),
    .wr_bw_n_i (wr_bw_n),
    .d_i       (d_i),       // write data straight from the pins
    .q_o       (q)
  );

  nobl_read_out u_read_out (
    .clk       (clk),
    .rst_i     (rst_i),
    .cen_n_i   (cen_n_i),
    .op_i      (op),
    .q_i       (q),
    .oe_n_i    (oe_n_i),
    .d_o       (d_o),
    .d_oe_o    (d_oe_o)
  );

endmodule

/* tb/nobl_sram_assertions.sv */
module nobl_sram_assertions (
  input logic clk,
  input logic rst_i,
  input logic cen_n_i,
  input logic oe_n_i,
  input logic d_oe_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // ********************************************************************
  // pin rules
  // ********************************************************************

  oe_gates_drive: assert property (@(posedge clk) disable iff (rst_i) oe_n_i |-> !d_oe_o)
    else $error("d_oe_o high while oe_n_i is high");

  reset_quiet: assert property (@(posedge clk) $fell(rst_i) |-> !d_oe_o)
    else $error("d_oe_o high in the first cycle after reset");

  // a disabled edge moves nothing, so only oe_n may change the drive
  stall_holds: assert property (@(posedge clk) disable iff (rst_i)
      ($past(cen_n_i) && !$past(rst_i) && $stable(oe_n_i)) |-> $stable(d_oe_o))
    else $error("d_oe_o changed across a stalled edge");

endmodule

bind nobl_sram_top nobl_sram_assertions u_assertions (
  .clk     (clk),
  .rst_i   (rst_i),
  .cen_n_i (cen_n_i),
  .oe_n_i  (oe_n_i),
  .d_oe_o  (d_oe_o)
);

/* tb/nobl_sram_tb.sv */
`include "nobl_settings.svh"

module nobl_sram_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int AW = `NOBL_ADDR_W;
  localparam int WW = `NOBL_WORD_W;
  localparam int BW = `NOBL_BYTE_W;
  localparam logic [2:0] CS_ON = 3'b010;    // {ce1_n, ce2, ce3_n} selected
  // reset plus rough cycle count of each test, doubled for margin
  localparam int LIMIT = 2 * (8 + 30 + 16 + 60 + 24 + 24 + 52);

  logic clk;
  logic rst_i;
  logic [AW-1:0] a_i;
  logic adv_i;
  logic we_n_i;
  logic [1:0] bw_n_i;
  logic ce1_n_i;
  logic ce2_i;
  logic ce3_n_i;
  logic cen_n_i;
  logic oe_n_i;
  logic mode_i;
  logic [WW-1:0] d_i;
  logic [WW-1:0] d_o;
  logic d_oe_o;

  // reference model state
  logic [WW-1:0] ref_mem [1 << AW];
  logic m_sel;                               // selection kept from the last load
  logic m_wr;                                // write type kept from the last load
  logic m_start;                             // a[0] of the last load
  logic [AW-1:0] m_addr;
  logic h1_rd, h1_wr, h2_wr;                 // commands one and two edges back
  logic [AW-1:0] h1_addr, h2_addr;
  logic [1:0] h1_bw, h2_bw;
  logic [WW-1:0] h1_data, h2_data, cmd_data;
  logic pend_v, out_v;                       // array stage, output stage
  logic [WW-1:0] pend_d, out_d;
  logic [AW-1:0] taddr [12];                 // addresses from the first test
  int seed = 13670;
  int cycle_cnt = 0;

  nobl_sram_top DUT (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ********************************************************************
  // helpers
  // ********************************************************************

  function automatic logic [WW-1:0] rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r[WW-1:0];
  endfunction

  function automatic logic [WW-1:0] bit_word(input logic b);
    return {{(WW-1){1'b0}}, b};
  endfunction

  task automatic check(input string name, input logic [WW-1:0] exp, input logic [WW-1:0] got);
    if (got !== exp)
    begin
      $display("mismatch %s: expected %h, got %h", name, exp, got);
      $display("test failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_outputs();
    check("d_oe_o", bit_word(out_v && !oe_n_i), bit_word(d_oe_o));
    if (out_v)
      check("d_o", out_d, d_o);              // also covers hold while oe_n is high
  endtask

  // one clock: write data for the command two edges back, model update, check
  task automatic tick();
    d_i = h2_wr ? h2_data : rand_word();     // junk when no write is due
    @(posedge clk);
    if (!cen_n_i)
    begin
      if (!adv_i)
      begin
        m_sel = !ce1_n_i && ce2_i && !ce3_n_i;
        m_wr  = !we_n_i;
        if (m_sel)
        begin
          m_addr  = a_i;
          m_start = a_i[0];
        end
      end
      else if (m_sel)                        // interleave from odd start counts down
        m_addr[1:0] = (m_start && mode_i) ? m_addr[1:0] - 2'd1 : m_addr[1:0] + 2'd1;
      out_v  = pend_v;
      out_d  = pend_d;
      pend_v = h1_rd;
      pend_d = ref_mem[h1_addr];             // read before this edge's write
      if (h2_wr && !h2_bw[0])
        ref_mem[h2_addr][BW-1:0] = d_i[BW-1:0];
      if (h2_wr && !h2_bw[1])
        ref_mem[h2_addr][WW-1:BW] = d_i[WW-1:BW];
      h2_wr   = h1_wr;
      h2_addr = h1_addr;
      h2_bw   = h1_bw;
      h2_data = h1_data;
      h1_rd   = m_sel && !m_wr;
      h1_wr   = m_sel && m_wr;               // bw = 11 is still a write
      h1_addr = m_addr;
      h1_bw   = bw_n_i;
      h1_data = cmd_data;
    end
    #1;
    check_outputs();
    #4;                                      // back at 5 ns after the edge
  endtask

  task automatic issue(input logic adv, input logic we_n, input logic [2:0] cs,
                       input logic [AW-1:0] a, input logic [1:0] bw, input logic [WW-1:0] data);
    cen_n_i = 1'b0;
    adv_i   = adv;
    we_n_i  = we_n;
    {ce1_n_i, ce2_i, ce3_n_i} = cs;
    a_i      = a;
    bw_n_i   = bw;
    cmd_data = data;
    tick();
  endtask

  task automatic load_write(input logic [AW-1:0] a, input logic [1:0] bw,
                            input logic [WW-1:0] data);
    issue(1'b0, 1'b0, CS_ON, a, bw, data);
  endtask

  task automatic load_read(input logic [AW-1:0] a);
    issue(1'b0, 1'b1, CS_ON, a, 2'b11, '0);
  endtask

  // pins other than adv and bw carry junk, bursts must ignore them
  task automatic burst_next(input logic [1:0] bw, input logic [WW-1:0] data);
    issue(1'b1, 1'b1, 3'b101, ~a_i, bw, data);
  endtask

  task automatic idle_cycle();
    issue(1'b0, 1'b1, 3'b110, a_i, 2'b11, '0);
  endtask

  task automatic stall_cycle();
    cen_n_i = 1'b1;
    tick();
  endtask

  task automatic set_oe(input logic v);
    oe_n_i = v;
    #1;
    check_outputs();                         // oe_n acts without a clock
  endtask

  // ********************************************************************
  // directed tests
  // ********************************************************************

  task automatic scattered_rw();
    for (int i = 0; i < 12; i++)
    begin
      taddr[i] = AW'(i * 83 + 17);           // scattered over the array
      load_write(taddr[i], 2'b00, rand_word());
    end
    for (int i = 0; i < 12; i++)
      load_read(taddr[i]);
    idle_cycle();
    idle_cycle();
  endtask

  task automatic byte_lane_writes();
    logic [1:0] pat [3];
    pat = '{2'b10, 2'b01, 2'b11};
    for (int i = 0; i < 3; i++)
      load_write(AW'(768 + i), 2'b00, WW'(18'h2AAAA + i));
    for (int i = 0; i < 3; i++)
      load_write(AW'(768 + i), pat[i], rand_word());
    idle_cycle();
    idle_cycle();
    for (int i = 0; i < 3; i++)
      load_read(AW'(768 + i));
    idle_cycle();
    idle_cycle();
  endtask

  task automatic burst_orders();
    logic [AW-1:0] base;
    logic [1:0] lo;
    for (int k = 0; k < 4; k++)
    begin
      mode_i = k[1];
      base   = AW'(256 + 8 * k + k % 2);     // start bit from k[0]
      load_write(base, 2'b00, rand_word());
      repeat (3) burst_next(2'b00, rand_word());
      idle_cycle();
      for (int j = 0; j < 4; j++)            // read back at the expected burst order
      begin
        lo = (base[0] && mode_i) ? base[1:0] - 2'(j) : base[1:0] + 2'(j);
        load_read({base[AW-1:2], lo});
      end
      load_read(base);
      repeat (3) burst_next(2'b11, '0);
      idle_cycle();
      idle_cycle();
    end
    mode_i = 1'b0;
  endtask

  task automatic clock_stall();
    for (int i = 0; i < 6; i++)
    begin
      load_write(AW'(512 + i), 2'b00, rand_word());
      if (i == 2)
        stall_cycle();                       // writes in flight hold their data
    end
    idle_cycle();
    load_read(AW'(512));
    load_read(AW'(513));
    repeat (3) stall_cycle();
    load_read(AW'(514));
    stall_cycle();
    load_read(AW'(515));
    load_read(AW'(516));
    repeat (2) stall_cycle();
    load_read(AW'(517));
    idle_cycle();
    stall_cycle();
    idle_cycle();
    idle_cycle();
  endtask

  task automatic deselect_and_oe();
    load_write(AW'(600), 2'b00, rand_word());
    load_write(AW'(601), 2'b00, rand_word());
    idle_cycle();
    load_read(AW'(600));
    issue(1'b0, 1'b1, 3'b110, AW'(600), 2'b11, '0);  // ce1_n high
    load_read(AW'(601));
    issue(1'b0, 1'b1, 3'b000, AW'(601), 2'b11, '0);  // ce2 low
    issue(1'b0, 1'b1, 3'b011, AW'(600), 2'b11, '0);  // ce3_n high
    load_write(AW'(602), 2'b11, rand_word());        // writes nothing
    load_read(AW'(601));
    idle_cycle();
    idle_cycle();
    stall_cycle();
    set_oe(1'b1);
    stall_cycle();
    set_oe(1'b0);
    idle_cycle();
    set_oe(1'b1);
    idle_cycle();
    set_oe(1'b0);
  endtask

  task automatic mixed_traffic();
    for (int i = 0; i < 16; i++)
    begin
      load_write(AW'(640 + i), 2'b00, rand_word());
      load_read(taddr[i % 12]);              // untouched here, no collisions
    end
    idle_cycle();
    for (int i = 0; i < 16; i++)
      load_read(AW'(640 + i));
    idle_cycle();
    idle_cycle();
  endtask

  // ********************************************************************
  // main sequence and timeout
  // ********************************************************************

  initial
  begin
    rst_i = 1'b1;
    a_i = '0;
    adv_i = 1'b0;
    we_n_i = 1'b1;
    bw_n_i = 2'b11;
    {ce1_n_i, ce2_i, ce3_n_i} = CS_ON;       // reads during reset must not reach the pins
    cen_n_i = 1'b0;
    oe_n_i = 1'b0;
    mode_i = 1'b0;
    d_i = '0;
    {m_sel, m_wr, m_start, h1_rd, h1_wr, h2_wr, pend_v, out_v} = '0;
    {m_addr, h1_addr, h2_addr, h1_bw, h2_bw} = '0;
    {h1_data, h2_data, cmd_data, pend_d, out_d} = '0;
    repeat (8) @(posedge clk);
    #5;
    rst_i = 1'b0;
    scattered_rw();
    byte_lane_writes();
    burst_orders();
    clock_stall();
    deselect_and_oe();
    mixed_traffic();
    $display("test passed");
    $finish;
  end

  initial
  begin
    while (cycle_cnt <= LIMIT)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("error: run went past %0d cycles without finishing", LIMIT);
    $display("test failed");
    $fatal(1, "timeout");
  end

endmodule
